//--- source/nes_pad_pkg.sv
package nes_pad_pkg;

  // serial report geometry
  localparam int pad_bits    = 8;
  localparam int report_bits = 24;

  // multitap signature bytes, sent after the second pad
  localparam logic [7:0] multitap_sig_port1 = 8'h08;
  localparam logic [7:0] multitap_sig_port2 = 8'h04;

  // upper report when only one pad sits on a port
  localparam logic [15:0] report_fill = 16'hffff;

  localparam int turbo_speed_bits = 3;

  // raw buttons of one player
  typedef struct packed {
    logic a;
    logic b;
    logic a_turbo;
    logic b_turbo;
    logic start;
    logic select;
    logic up;
    logic down;
    logic left;
    logic right;
  } pad_buttons_t;

  // one pad byte as shifted out, lsb goes first
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } pad_byte_t;

  // console side strobe and per-port clocks
  typedef struct packed {
    logic strobe;
    logic clock1;
    logic clock2;
  } port_ctrl_t;

  // data word the console samples on each port read
  typedef struct packed {
    logic       zapper_trigger;
    logic       zapper_light;
    logic [1:0] reserved;
    logic       serial;
  } port_data_t;

endpackage

//--- source/turbo_phase_gen.sv
`timescale 1ns/1ps

module turbo_phase_gen
  import nes_pad_pkg::*;
(
  input  logic                        clk_ppu_21_47,
  input  logic                        reset_nes,
  input  logic                        vsync,
  input  logic [turbo_speed_bits-1:0] turbo_speed,
  output logic                        turbo_phase
);

  logic                        vsync_q;
  logic                        vsync_rise;
  logic [turbo_speed_bits-1:0] frame_count;

  // one frame per rising edge of vsync
  assign vsync_rise = vsync & ~vsync_q;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      vsync_q <= 1'b0;
    end else begin
      vsync_q <= vsync;
    end
  end

  // count frames, flip the phase every turbo_speed + 1 of them
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      frame_count <= '0;
      turbo_phase <= 1'b0;
    end else if (vsync_rise) begin
      if (frame_count == turbo_speed) begin
        frame_count <= '0;
        turbo_phase <= ~turbo_phase;
      end else begin
        frame_count <= frame_count + 1'b1;
      end
    end
  end

  // the phase is shared by all four players, so autofire
  // on different pads stays in step

endmodule

//--- source/pad_report_decode.sv
`timescale 1ns/1ps

module pad_report_decode
  import nes_pad_pkg::*;
(
  input  pad_buttons_t           player1,
  input  pad_buttons_t           player2,
  input  pad_buttons_t           player3,
  input  pad_buttons_t           player4,
  input  logic                   turbo_phase,
  input  logic                   multitap_enabled,
  input  logic                   swap_controllers,
  output logic [report_bits-1:0] report1,
  output logic [report_bits-1:0] report2
);

  // merge turbo into a and b, reorder into shift order
  function automatic pad_byte_t to_pad_byte(input pad_buttons_t p, input logic phase);
    pad_byte_t pb;
    pb.a      = p.a | (p.a_turbo & phase);
    pb.b      = p.b | (p.b_turbo & phase);
    pb.select = p.select;
    pb.start  = p.start;
    pb.up     = p.up;
    pb.down   = p.down;
    pb.left   = p.left;
    pb.right  = p.right;
    return pb;
  endfunction

  pad_byte_t pad1;
  pad_byte_t pad2;
  pad_byte_t pad3;
  pad_byte_t pad4;

  logic [pad_bits-1:0]             pad_x;
  logic [pad_bits-1:0]             pad_y;
  logic [report_bits-pad_bits-1:0] upper1;
  logic [report_bits-pad_bits-1:0] upper2;

  always_comb begin
    pad1 = to_pad_byte(player1, turbo_phase);
    pad2 = to_pad_byte(player2, turbo_phase);
    pad3 = to_pad_byte(player3, turbo_phase);
    pad4 = to_pad_byte(player4, turbo_phase);
  end

  // first byte on each port, players one and two may trade places
  always_comb begin
    if (swap_controllers) begin
      pad_x = pad2;
      pad_y = pad1;
    end else begin
      pad_x = pad1;
      pad_y = pad2;
    end
  end

  // upper 16 bits: extra pad plus signature, or all ones
  always_comb begin
    if (multitap_enabled) begin
      upper1 = {multitap_sig_port1, pad3};
      upper2 = {multitap_sig_port2, pad4};
    end else begin
      upper1 = report_fill;
      upper2 = report_fill;
    end
  end

  assign report1 = {upper1, pad_x};
  assign report2 = {upper2, pad_y};

endmodule

//--- source/serial_port_shifter.sv
`timescale 1ns/1ps

module serial_port_shifter
  import nes_pad_pkg::*;
(
  input  logic                   clk_ppu_21_47,
  input  logic                   reset_nes,
  input  logic                   load,
  input  logic                   port_clock,
  input  logic [report_bits-1:0] report,
  output logic                   serial
);

  logic [report_bits-1:0] shift_reg;
  logic                   port_clock_q;
  logic                   port_clock_fall;

  // falling edge seen on the first cycle the clock samples low
  assign port_clock_fall = port_clock_q & ~port_clock;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      port_clock_q <= 1'b0;
    end else begin
      port_clock_q <= port_clock;
    end
  end

  // shift takes priority over a load in the same cycle
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      shift_reg <= '0;
    end else if (port_clock_fall) begin
      shift_reg <= {1'b0, shift_reg[report_bits-1:1]};
    end else if (load) begin
      shift_reg <= report;
    end
  end

  // zeros follow once the 24 report bits are out
  assign serial = shift_reg[0];

endmodule

//--- source/port_data_assembly.sv
`timescale 1ns/1ps

module port_data_assembly
  import nes_pad_pkg::*;
(
  input  logic       clk_ppu_21_47,
  input  logic       reset_nes,
  input  logic       serial1,
  input  logic       serial2,
  input  logic       gun_enabled,
  input  logic       zapper_trigger,
  input  logic       zapper_light,
  output port_data_t joypad1_data,
  output port_data_t joypad2_data
);

  // two stage synchronizers, bit 1 is the stable copy
  logic [1:0] trigger_sync;
  logic [1:0] light_sync;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      trigger_sync <= 2'b00;
      light_sync   <= 2'b00;
    end else begin
      trigger_sync <= {trigger_sync[0], zapper_trigger};
      light_sync   <= {light_sync[0], zapper_light};
    end
  end

  // port 1 carries only the pad line
  always_comb begin
    joypad1_data                = '0;
    joypad1_data.serial         = serial1;
  end

  // external gun lives on port 2
  always_comb begin
    joypad2_data                = '0;
    joypad2_data.serial         = serial2;
    joypad2_data.zapper_trigger = gun_enabled & trigger_sync[1];
    joypad2_data.zapper_light   = gun_enabled & light_sync[1];
  end

endmodule

//--- source/nes_controller_top.sv
`timescale 1ns/1ps

module nes_controller_top
  import nes_pad_pkg::*;
(
  input  logic                        clk_ppu_21_47,
  input  logic                        reset_nes,

  input  pad_buttons_t                player1,
  input  pad_buttons_t                player2,
  input  pad_buttons_t                player3,
  input  pad_buttons_t                player4,

  input  logic                        vsync,
  input  logic [turbo_speed_bits-1:0] turbo_speed,
  input  logic                        multitap_enabled,
  input  logic                        swap_controllers,

  // bit 1 picks the external light gun
  input  logic [1:0]                  lightgun_enabled,
  input  logic                        zapper_trigger,
  input  logic                        zapper_light,

  input  port_ctrl_t                  joypad,
  output port_data_t                  joypad1_data,
  output port_data_t                  joypad2_data
);

  logic                   turbo_phase;
  logic [report_bits-1:0] report1;
  logic [report_bits-1:0] report2;
  logic                   serial1;
  logic                   serial2;

  turbo_phase_gen turbo_gen (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .vsync         (vsync),
    .turbo_speed   (turbo_speed),
    .turbo_phase   (turbo_phase)
  );

  pad_report_decode report_decode (
    .player1          (player1),
    .player2          (player2),
    .player3          (player3),
    .player4          (player4),
    .turbo_phase      (turbo_phase),
    .multitap_enabled (multitap_enabled),
    .swap_controllers (swap_controllers),
    .report1          (report1),
    .report2          (report2)
  );

  // both ports share the strobe, each has its own clock
  serial_port_shifter port1_shifter (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .load          (joypad.strobe),
    .port_clock    (joypad.clock1),
    .report        (report1),
    .serial        (serial1)
  );

  serial_port_shifter port2_shifter (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .load          (joypad.strobe),
    .port_clock    (joypad.clock2),
    .report        (report2),
    .serial        (serial2)
  );

  port_data_assembly data_assembly (
    .clk_ppu_21_47  (clk_ppu_21_47),
    .reset_nes      (reset_nes),
    .serial1        (serial1),
    .serial2        (serial2),
    .gun_enabled    (lightgun_enabled[1]),
    .zapper_trigger (zapper_trigger),
    .zapper_light   (zapper_light),
    .joypad1_data   (joypad1_data),
    .joypad2_data   (joypad2_data)
  );

endmodule

//--- verification/controller_assertions.sv
`timescale 1ns/1ps

module controller_assertions
  import nes_pad_pkg::*;
(
  input logic       clk_ppu_21_47,
  input logic       reset_nes,
  input logic [1:0] lightgun_enabled,
  input port_data_t joypad1_data,
  input port_data_t joypad2_data
);

  // reserved field is tied low on both ports
  reserved_clear: assert property (@(posedge clk_ppu_21_47) disable iff (reset_nes)
    (joypad1_data.reserved == 2'b00) && (joypad2_data.reserved == 2'b00))
    else $error("reserved bits set on a port data word");

  // no gun bits on port 2 unless the external gun is selected
  gun_off_quiet: assert property (@(posedge clk_ppu_21_47) disable iff (reset_nes)
    !lightgun_enabled[1] |-> (!joypad2_data.zapper_trigger && !joypad2_data.zapper_light))
    else $error("light gun bits set on port 2 while the gun is disabled");

  // port 1 never carries the gun
  port1_no_gun: assert property (@(posedge clk_ppu_21_47) disable iff (reset_nes)
    !joypad1_data.zapper_trigger && !joypad1_data.zapper_light)
    else $error("light gun bits set on port 1");

endmodule

bind nes_controller_top controller_assertions assertions (
  .clk_ppu_21_47    (clk_ppu_21_47),
  .reset_nes        (reset_nes),
  .lightgun_enabled (lightgun_enabled),
  .joypad1_data     (joypad1_data),
  .joypad2_data     (joypad2_data)
);

//--- verification/controller_tb.sv
`timescale 1ns/1ps

module controller_tb
  import nes_pad_pkg::*;
();

  logic                        clk_ppu_21_47;
  logic                        reset_nes;
  pad_buttons_t                player1;
  pad_buttons_t                player2;
  pad_buttons_t                player3;
  pad_buttons_t                player4;
  logic                        vsync;
  logic [turbo_speed_bits-1:0] turbo_speed;
  logic                        multitap_enabled;
  logic                        swap_controllers;
  logic [1:0]                  lightgun_enabled;
  logic                        zapper_trigger;
  logic                        zapper_light;
  port_ctrl_t                  joypad;
  port_data_t                  joypad1_data;
  port_data_t                  joypad2_data;

  int    seed = 32'h70c93207;
  string current_test;
  int    test_checks;
  int    test_errors;
  int    total_checks = 0;
  int    total_errors = 0;

  // expected turbo state, mirrors the frame rule
  logic                        phase_model;
  logic [turbo_speed_bits-1:0] frame_model;

  nes_controller_top dut (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .player1          (player1),
    .player2          (player2),
    .player3          (player3),
    .player4          (player4),
    .vsync            (vsync),
    .turbo_speed      (turbo_speed),
    .multitap_enabled (multitap_enabled),
    .swap_controllers (swap_controllers),
    .lightgun_enabled (lightgun_enabled),
    .zapper_trigger   (zapper_trigger),
    .zapper_light     (zapper_light),
    .joypad           (joypad),
    .joypad1_data     (joypad1_data),
    .joypad2_data     (joypad2_data)
  );

  always #50 clk_ppu_21_47 = ~clk_ppu_21_47;

  // console byte order: a b select start up down left right
  function automatic logic [7:0] pad_byte(input pad_buttons_t p, input logic phase);
    logic [7:0] r;
    r[0] = p.a | (p.a_turbo & phase);
    r[1] = p.b | (p.b_turbo & phase);
    r[2] = p.select;
    r[3] = p.start;
    r[4] = p.up;
    r[5] = p.down;
    r[6] = p.left;
    r[7] = p.right;
    return r;
  endfunction

  function automatic logic [23:0] model_report(input int port);
    logic [7:0]  low;
    logic [15:0] high;
    if (port == 1) begin
      low  = swap_controllers ? pad_byte(player2, phase_model) : pad_byte(player1, phase_model);
      high = multitap_enabled ? {multitap_sig_port1, pad_byte(player3, phase_model)}
                              : report_fill;
    end else begin
      low  = swap_controllers ? pad_byte(player1, phase_model) : pad_byte(player2, phase_model);
      high = multitap_enabled ? {multitap_sig_port2, pad_byte(player4, phase_model)}
                              : report_fill;
    end
    return {high, low};
  endfunction

  task automatic apply_reset();
    reset_nes = 1'b1;
    repeat (5) @(negedge clk_ppu_21_47);
    reset_nes   = 1'b0;
    phase_model = 1'b0;
    frame_model = '0;
  endtask

  task automatic start_test(input string name);
    current_test = name;
    test_checks  = 0;
    test_errors  = 0;
  endtask

  task automatic finish_test();
    $display("test %s finished: %0d checks, %0d errors", current_test, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
  endtask

  task automatic load_random_pads();
    logic [31:0] rnd;
    rnd = $random(seed);
    player1 = rnd[9:0];
    rnd = $random(seed);
    player2 = rnd[9:0];
    rnd = $random(seed);
    player3 = rnd[9:0];
    rnd = $random(seed);
    player4 = rnd[9:0];
  endtask

  task automatic pulse_vsync();
    vsync = 1'b1;
    repeat (2) @(negedge clk_ppu_21_47);
    vsync = 1'b0;
    repeat (2) @(negedge clk_ppu_21_47);
    if (frame_model == turbo_speed) begin
      frame_model = '0;
      phase_model = ~phase_model;
    end else begin
      frame_model++;
    end
  endtask

  // latch with strobe, then sample one bit per port clock pulse
  task automatic read_report(input int port, output logic [31:0] bits);
    bits = '0;
    @(negedge clk_ppu_21_47);
    joypad.strobe = 1'b1;
    repeat (3) @(negedge clk_ppu_21_47);
    joypad.strobe = 1'b0;
    repeat (2) @(negedge clk_ppu_21_47);
    for (int i = 0; i < 32; i++) begin
      bits[i] = (port == 1) ? joypad1_data.serial : joypad2_data.serial;
      if (port == 1) joypad.clock1 = 1'b1;
      else joypad.clock2 = 1'b1;
      repeat (3) @(negedge clk_ppu_21_47);
      if (port == 1) joypad.clock1 = 1'b0;
      else joypad.clock2 = 1'b0;
      repeat (3) @(negedge clk_ppu_21_47);
    end
  endtask

  task automatic compare_port_reports(input int rounds);
    logic [31:0] bits;
    logic [31:0] expected;
    for (int r = 0; r < rounds; r++) begin
      load_random_pads();
      for (int port = 1; port <= 2; port++) begin
        read_report(port, bits);
        // zeros follow the 24 report bits
        expected = {8'h00, model_report(port)};
        test_checks++;
        if (bits !== expected) begin
          test_errors++;
          $display("Mismatch in %s port %0d: expected %h, actual %h",
                   current_test, port, expected, bits);
        end
      end
    end
  endtask

  // wait for port 2 gun bits, gives up after 10 cycles
  task automatic wait_port2_gun(input logic trigger, input logic light, output int cycles);
    cycles = 0;
    while ({joypad2_data.zapper_trigger, joypad2_data.zapper_light} !== {trigger, light}
           && cycles < 10) begin
      @(negedge clk_ppu_21_47);
      cycles++;
    end
  endtask

  task automatic test_reset_state();
    start_test("reset_state");
    apply_reset();
    test_checks++;
    if ({joypad1_data, joypad2_data} !== 10'b0) begin
      test_errors++;
      $display("Mismatch in %s: expected %h, actual %h", current_test, 10'b0,
               {joypad1_data, joypad2_data});
    end
    finish_test();
  endtask

  task automatic test_single_pads();
    start_test("single_pads");
    multitap_enabled = 1'b0;
    swap_controllers = 1'b0;
    compare_port_reports(3);
    finish_test();
  endtask

  task automatic test_swapped_pads();
    start_test("swapped_pads");
    multitap_enabled = 1'b0;
    swap_controllers = 1'b1;
    compare_port_reports(3);
    finish_test();
  endtask

  task automatic test_multitap();
    start_test("multitap");
    multitap_enabled = 1'b1;
    swap_controllers = 1'b0;
    compare_port_reports(2);
    swap_controllers = 1'b1;
    compare_port_reports(2);
    multitap_enabled = 1'b0;
    swap_controllers = 1'b0;
    finish_test();
  endtask

  // both turbo buttons held, a and b follow the phase
  task automatic test_turbo();
    logic [31:0] bits;
    start_test("turbo");
    apply_reset();
    player1 = '0;
    player1.a_turbo = 1'b1;
    player1.b_turbo = 1'b1;
    turbo_speed = 3'd2;
    for (int frame = 0; frame <= 8; frame++) begin
      if (frame > 0) pulse_vsync();
      read_report(1, bits);
      test_checks++;
      if (bits[1:0] !== {2{phase_model}}) begin
        test_errors++;
        $display("Mismatch in %s frame %0d: expected %h, actual %h",
                 current_test, frame, {2{phase_model}}, bits[1:0]);
      end
    end
    turbo_speed = '0;
    finish_test();
  endtask

  task automatic test_light_gun();
    int cycles;
    start_test("light_gun");
    @(negedge clk_ppu_21_47);
    lightgun_enabled = 2'b10;
    zapper_trigger   = 1'b1;
    wait_port2_gun(1'b1, 1'b0, cycles);
    test_checks++;
    if (joypad2_data.zapper_trigger !== 1'b1) begin
      test_errors++;
      $display("%s: trigger never reached port 2 within 10 cycles", current_test);
    end else if (cycles != 2) begin
      test_errors++;
      $display("Mismatch in %s trigger latency: expected %0d, actual %0d",
               current_test, 2, cycles);
    end
    zapper_light = 1'b1;
    wait_port2_gun(1'b1, 1'b1, cycles);
    test_checks++;
    if (joypad2_data.zapper_light !== 1'b1) begin
      test_errors++;
      $display("%s: light never reached port 2 within 10 cycles", current_test);
    end else if (cycles != 2) begin
      test_errors++;
      $display("Mismatch in %s light latency: expected %0d, actual %0d",
               current_test, 2, cycles);
    end
    test_checks++;
    if ({joypad1_data.zapper_trigger, joypad1_data.zapper_light} !== 2'b00) begin
      test_errors++;
      $display("Mismatch in %s port 1 gun bits: expected %h, actual %h", current_test,
               2'b00, {joypad1_data.zapper_trigger, joypad1_data.zapper_light});
    end
    zapper_trigger = 1'b0;
    zapper_light   = 1'b0;
    wait_port2_gun(1'b0, 1'b0, cycles);
    test_checks++;
    if ({joypad2_data.zapper_trigger, joypad2_data.zapper_light} !== 2'b00) begin
      test_errors++;
      $display("%s: gun bits on port 2 did not clear within 10 cycles", current_test);
    end
    // gun disabled, inputs active: port 2 must stay quiet
    lightgun_enabled = 2'b00;
    zapper_trigger   = 1'b1;
    zapper_light     = 1'b1;
    repeat (6) begin
      @(negedge clk_ppu_21_47);
      test_checks++;
      if ({joypad2_data.zapper_trigger, joypad2_data.zapper_light} !== 2'b00) begin
        test_errors++;
        $display("Mismatch in %s disabled gun: expected %h, actual %h", current_test,
                 2'b00, {joypad2_data.zapper_trigger, joypad2_data.zapper_light});
      end
    end
    zapper_trigger = 1'b0;
    zapper_light   = 1'b0;
    finish_test();
  endtask

  initial begin
    clk_ppu_21_47    = 1'b0;
    reset_nes        = 1'b1;
    player1          = '0;
    player2          = '0;
    player3          = '0;
    player4          = '0;
    vsync            = 1'b0;
    turbo_speed      = '0;
    multitap_enabled = 1'b0;
    swap_controllers = 1'b0;
    lightgun_enabled = 2'b00;
    zapper_trigger   = 1'b0;
    zapper_light     = 1'b0;
    joypad           = '0;
    phase_model      = 1'b0;
    frame_model      = '0;

    test_reset_state();
    test_single_pads();
    test_swapped_pads();
    test_multitap();
    test_turbo();
    test_light_gun();

    $display("%0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
source/nes_pad_pkg.sv
source/turbo_phase_gen.sv
source/pad_report_decode.sv
source/serial_port_shifter.sv
source/port_data_assembly.sv
source/nes_controller_top.sv
verification/controller_assertions.sv
verification/controller_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module controller_tb \
  -Mdir obj_dir \
  -f files.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/Vcontroller_tb)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -q "ALL CHECKS PASSED"; then
  exit 0
else
  exit 1
fi
